// ==== uart_core.f ====
+incdir+logic
+incdir+dv
logic/uart_frame_pkg.sv
logic/uart_fsm_pkg.sv
logic/baud_gen.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_core.sv
dv/uart_core_tb.sv

// ==== Makefile ====
# Verilator build and run of the UART core testbench

VERILATOR ?= verilator
TOP       ?= uart_core_tb
FILELIST  ?= uart_core.f
BUILD_DIR ?= build
LOG       ?= $(BUILD_DIR)/sim.log
VFLAGS    ?= --binary --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run and check the log"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR)

// ==== dv/uart_core_tests.svh ====
// *********************************************************************
// Directed tests, host handshake tasks, rx line driver and tx monitor
// *********************************************************************

`ifndef UART_CORE_TESTS_SVH
`define UART_CORE_TESTS_SVH

task automatic fail_run(input string line);
    $display("%s", line);
    $display("TEST FAILED");
    $fatal(1, "stopped at the first failure");
endtask

task automatic expect_equal(input int got, input int exp, input string what);
    assert (got == exp) else begin
        fail_run($sformatf("** Error @ %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp));
    end
endtask

// Parity bit from the mode rules, word already masked
function automatic logic calc_parity(uart_frame_pkg::parity_e mode, uart_frame_pkg::data_t w);
    case (mode)
        uart_frame_pkg::par_odd:    return ~(^w);     // Total ones odd
        uart_frame_pkg::par_even:   return ^w;        // Total ones even
        uart_frame_pkg::par_stick1: return 1'b1;
        default:                    return 1'b0;
    endcase
endfunction

function automatic uart_frame_pkg::data_t mask_word(uart_frame_pkg::data_t w, int size);
    return w & uart_frame_pkg::data_t'((32'd1 << size) - 32'd1);
endfunction

task automatic set_format(input int size, input uart_frame_pkg::parity_e mode,
                          input logic stops2, input logic loop);
    @(posedge clk);
    data_size   <= uart_frame_pkg::data_size_t'(size);
    parity      <= mode;
    two_stop    <= stops2;
    loopback_en <= loop;
endtask

task automatic send_word(input uart_frame_pkg::data_t w);
    @(posedge clk);
    tx_req  <= 1'b1;
    tx_data <= w;
    @(negedge clk);
    while (!tx_ack) @(negedge clk);
    expect_equal(int'(tx), 0, "tx start bit at ack");
    @(posedge clk);
    tx_req <= 1'b0;
    @(negedge clk);
    while (tx_ack) @(negedge clk);
endtask

// Samples the tx pin near mid-bit, called right after send_word
task automatic watch_tx_frame(input uart_frame_pkg::data_t word);
    uart_frame_pkg::data_t w;
    int                    size;
    size = int'(data_size);
    w    = mask_word(word, size);
    repeat (BIT_CLKS / 2) @(negedge clk);
    expect_equal(int'(tx), 0, "tx start bit");
    for (int i = 0; i < size; i++) begin
        repeat (BIT_CLKS) @(negedge clk);
        expect_equal(int'(tx), int'(w[i]), "tx data bit");
    end
    if (parity != uart_frame_pkg::par_none) begin
        repeat (BIT_CLKS) @(negedge clk);
        expect_equal(int'(tx), int'(calc_parity(parity, w)), "tx parity bit");
    end
    repeat (BIT_CLKS) @(negedge clk);
    expect_equal(int'(tx), 1, "tx stop bit");
    if (two_stop) begin
        repeat (BIT_CLKS) @(negedge clk);
        expect_equal(int'(tx), 1, "tx second stop bit");
    end
endtask

task automatic receive_word(input uart_frame_pkg::data_t exp, input logic perr,
                            input logic ferr);
    @(negedge clk);
    while (!rx_req) @(negedge clk);
    expect_equal(int'(rx_data), int'(exp), "rx_data");
    expect_equal(int'(rx_parity_err), int'(perr), "rx_parity_err");
    expect_equal(int'(rx_frame_err), int'(ferr), "rx_frame_err");
    @(posedge clk);
    rx_ack <= 1'b1;
    @(negedge clk);
    while (rx_req) @(negedge clk);
    @(posedge clk);
    rx_ack <= 1'b0;
endtask

// Called on a rising edge, holds the level for one bit
task automatic hold_line(input logic level);
    rx <= level;
    repeat (BIT_CLKS) @(posedge clk);
endtask

task automatic drive_frame(input uart_frame_pkg::data_t word, input logic bad_parity,
                           input logic bad_stop);
    uart_frame_pkg::data_t w;
    @(posedge clk);
    w = mask_word(word, int'(data_size));
    hold_line(1'b0);                                // Start
    for (int i = 0; i < int'(data_size); i++) begin
        hold_line(w[i]);                            // LSB first
    end
    if (parity != uart_frame_pkg::par_none) begin
        hold_line(calc_parity(parity, w) ^ bad_parity);
    end
    hold_line(!bad_stop);
    if (two_stop) begin
        hold_line(1'b1);
    end
    hold_line(1'b1);                                // Idle gap
endtask

task automatic check_idle_after_reset();
    @(negedge clk);
    expect_equal(int'(tx), 1, "tx after reset");
    expect_equal(int'(tx_ack), 0, "tx_ack after reset");
    expect_equal(int'(rx_req), 0, "rx_req after reset");
    expect_equal(int'(rx_overrun), 0, "rx_overrun after reset");
endtask

task automatic loop_full_words();
    uart_frame_pkg::data_t w;
    set_format(8, uart_frame_pkg::par_none, 1'b0, 1'b1);
    repeat (4) begin
        w = uart_frame_pkg::data_t'($urandom());
        send_word(w);
        watch_tx_frame(w);
        receive_word(w, 1'b0, 1'b0);
    end
endtask

task automatic loop_masked_formats();
    uart_frame_pkg::data_t   w;
    uart_frame_pkg::parity_e modes[3];
    modes[0] = uart_frame_pkg::par_even;
    modes[1] = uart_frame_pkg::par_stick1;
    modes[2] = uart_frame_pkg::par_odd;
    foreach (modes[m]) begin
        set_format(5, modes[m], 1'b1, 1'b1);
        repeat (3) begin
            w = uart_frame_pkg::data_t'($urandom());
            send_word(w);                           // Upper bits dropped by the DUT
            watch_tx_frame(w);
            receive_word(mask_word(w, 5), 1'b0, 1'b0);
        end
    end
endtask

task automatic detect_line_errors();
    uart_frame_pkg::data_t w;
    set_format(8, uart_frame_pkg::par_even, 1'b0, 1'b0);
    w = uart_frame_pkg::data_t'($urandom());
    drive_frame(w, 1'b1, 1'b0);                     // Inverted parity bit
    receive_word(w, 1'b1, 1'b0);
    w = uart_frame_pkg::data_t'($urandom());
    drive_frame(w, 1'b0, 1'b1);                     // Stop bit low
    receive_word(w, 1'b0, 1'b1);
endtask

task automatic keep_word_on_overrun();
    uart_frame_pkg::data_t w1;
    uart_frame_pkg::data_t w2;
    int                    base;
    set_format(8, uart_frame_pkg::par_none, 1'b0, 1'b0);
    w1   = uart_frame_pkg::data_t'($urandom());
    w2   = uart_frame_pkg::data_t'($urandom());
    base = overrun_seen;
    drive_frame(w1, 1'b0, 1'b0);
    drive_frame(w2, 1'b0, 1'b0);                    // First word still unacknowledged
    expect_equal(overrun_seen - base, 1, "rx_overrun pulse count");
    receive_word(w1, 1'b0, 1'b0);
endtask

`endif

// ==== dv/uart_core_tb.sv ====
// *********************************************************************
// UART core testbench top: clock, reset, DUT, timeout and test order
// *********************************************************************

`default_nettype none
`include "uart_consts.svh"

module uart_core_tb;

    localparam int SEED       = 84370;
    localparam int PRESCALE   = 3;
    localparam int BIT_CLKS   = `UART_SAMPLES * (PRESCALE + 1);    // 64 clocks per bit
    localparam int NUM_FRAMES = 17;
    localparam int FRAME_CLKS = 13 * BIT_CLKS;                     // 12 bits plus idle gap
    localparam int TIMEOUT_CYCLES = 2 * NUM_FRAMES * FRAME_CLKS + 1000;

    logic                       clk = 1'b0;
    logic                       resetn;
    uart_frame_pkg::prescale_t  prescale;
    uart_frame_pkg::data_size_t data_size;
    uart_frame_pkg::parity_e    parity;
    logic                       two_stop;
    logic                       loopback_en;
    logic                       tx_req;
    uart_frame_pkg::data_t      tx_data;
    logic                       tx_ack;
    logic                       rx_ack;
    logic                       rx_req;
    uart_frame_pkg::data_t      rx_data;
    logic                       rx_parity_err;
    logic                       rx_frame_err;
    logic                       rx_overrun;
    logic                       rx;
    logic                       tx;

    int cycle_count  = 0;
    int overrun_seen = 0;

    always #2 clk = ~clk;

    uart_core uart_core_i (
        .clk           (clk),
        .resetn        (resetn),
        .prescale      (prescale),
        .data_size     (data_size),
        .parity        (parity),
        .two_stop      (two_stop),
        .loopback_en   (loopback_en),
        .tx_req        (tx_req),
        .tx_data       (tx_data),
        .tx_ack        (tx_ack),
        .rx_ack        (rx_ack),
        .rx_req        (rx_req),
        .rx_data       (rx_data),
        .rx_parity_err (rx_parity_err),
        .rx_frame_err  (rx_frame_err),
        .rx_overrun    (rx_overrun),
        .rx            (rx),
        .tx            (tx)
    );

    `include "uart_core_tests.svh"

    // One count per clock that rx_overrun is high
    always @(posedge clk) begin
        if (resetn && rx_overrun) begin
            overrun_seen <= overrun_seen + 1;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            fail_run($sformatf("Timeout: tests still running after %0d cycles", cycle_count));
        end
    end

    initial begin
        void'($urandom(SEED));
        resetn      <= 1'b0;
        prescale    <= uart_frame_pkg::prescale_t'(PRESCALE);
        data_size   <= uart_frame_pkg::data_size_t'(8);
        parity      <= uart_frame_pkg::par_none;
        two_stop    <= 1'b0;
        loopback_en <= 1'b0;
        tx_req      <= 1'b0;
        tx_data     <= '0;
        rx_ack      <= 1'b0;
        rx          <= 1'b1;                    // Idle line
        repeat (5) @(posedge clk);
        resetn <= 1'b1;
        repeat (2) @(posedge clk);

        check_idle_after_reset();
        loop_full_words();
        loop_masked_formats();
        detect_line_errors();
        keep_word_on_overrun();

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/uart_core.sv ====
// *********************************************************************
// UART core top: baud generator, both stages and loopback select
// *********************************************************************

`default_nettype none

module uart_core (
    input  wire                             clk,
    input  wire                             resetn,
    input  wire uart_frame_pkg::prescale_t  prescale,
    input  wire uart_frame_pkg::data_size_t data_size,
    input  wire uart_frame_pkg::parity_e    parity,
    input  wire                             two_stop,
    input  wire                             loopback_en,
    input  wire                             tx_req,
    input  wire uart_frame_pkg::data_t      tx_data,
    output logic                            tx_ack,
    input  wire                             rx_ack,
    output logic                            rx_req,
    output uart_frame_pkg::data_t           rx_data,
    output logic                            rx_parity_err,
    output logic                            rx_frame_err,
    output logic                            rx_overrun,
    input  wire                             rx,
    output logic                            tx
);

    logic tick;
    logic rx_line;

    assign rx_line = loopback_en ? tx : rx;     // Internal loopback

    baud_gen baud_gen_i (
        .clk      (clk),
        .resetn   (resetn),
        .prescale (prescale),
        .tick     (tick)
    );

    uart_tx uart_tx_i (
        .clk       (clk),
        .resetn    (resetn),
        .tick      (tick),
        .data_size (data_size),
        .parity    (parity),
        .two_stop  (two_stop),
        .tx_req    (tx_req),
        .tx_data   (tx_data),
        .tx_ack    (tx_ack),
        .tx        (tx)
    );

    uart_rx uart_rx_i (
        .clk           (clk),
        .resetn        (resetn),
        .tick          (tick),
        .data_size     (data_size),
        .parity        (parity),
        .two_stop      (two_stop),
        .line          (rx_line),
        .rx_ack        (rx_ack),
        .rx_req        (rx_req),
        .rx_data       (rx_data),
        .rx_parity_err (rx_parity_err),
        .rx_frame_err  (rx_frame_err),
        .rx_overrun    (rx_overrun)
    );

endmodule

`default_nettype wire

// ==== logic/uart_rx.sv ====
// *********************************************************************
// Receive stage: synchronizer, sampler, deserializer, error checks
// and the holding register behind the host req/ack handshake
// *********************************************************************

`default_nettype none
`include "uart_consts.svh"

module uart_rx (
    input  wire                             clk,
    input  wire                             resetn,
    input  wire                             tick,
    input  wire uart_frame_pkg::data_size_t data_size,
    input  wire uart_frame_pkg::parity_e    parity,
    input  wire                             two_stop,
    input  wire                             line,
    input  wire                             rx_ack,
    output logic                            rx_req,
    output uart_frame_pkg::data_t           rx_data,
    output logic                            rx_parity_err,
    output logic                            rx_frame_err,
    output logic                            rx_overrun
);

    logic [1:0]                sync_q;
    logic                      line_s;
    uart_fsm_pkg::line_state_e state;
    uart_fsm_pkg::sample_cnt_t sample_cnt;
    uart_fsm_pkg::bit_cnt_t    bit_cnt;
    uart_frame_pkg::data_t     shreg;
    uart_frame_pkg::data_t     word;
    logic                      perr_q;
    logic                      ferr_q;
    logic                      bit_end;
    logic                      mid_start;
    logic                      last_bit;
    logic                      frame_done;

    assign line_s     = sync_q[1];
    assign bit_end    = tick && (sample_cnt == uart_fsm_pkg::sample_cnt_t'(`UART_SAMPLES - 1));
    assign mid_start  = tick && (sample_cnt == uart_fsm_pkg::sample_cnt_t'(`UART_SAMPLES/2 - 1));
    assign last_bit   = ({1'b0, bit_cnt} == data_size - 4'd1);
    assign word       = shreg >> (`UART_DATA_W - data_size);   // Right-align, upper bits zero
    assign frame_done = bit_end && ((state == uart_fsm_pkg::st_stop0 && !two_stop) ||
                                    state == uart_fsm_pkg::st_stop1);

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            sync_q <= 2'b11;
        end else begin
            sync_q <= {sync_q[0], line};
        end
    end

    // Data bits arrive LSB first and enter at the top
    always_ff @(posedge clk) begin
        if (bit_end && state == uart_fsm_pkg::st_data) begin
            shreg <= {line_s, shreg[`UART_DATA_W-1:1]};
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state      <= uart_fsm_pkg::st_idle;
            sample_cnt <= '0;
            bit_cnt    <= '0;
            perr_q     <= 1'b0;
            ferr_q     <= 1'b0;
        end else begin
            if (tick) begin
                sample_cnt <= sample_cnt + 1'b1;
            end
            case (state)
                uart_fsm_pkg::st_idle: begin
                    if (tick && !line_s) begin
                        state      <= uart_fsm_pkg::st_start;
                        sample_cnt <= '0;
                    end
                end
                uart_fsm_pkg::st_start: begin
                    if (mid_start) begin
                        // A start bit gone high by mid-bit was noise
                        state      <= line_s ? uart_fsm_pkg::st_idle : uart_fsm_pkg::st_data;
                        sample_cnt <= '0;
                        bit_cnt    <= '0;
                        perr_q     <= 1'b0;
                        ferr_q     <= 1'b0;
                    end
                end
                uart_fsm_pkg::st_data: begin
                    if (bit_end) begin
                        if (!last_bit) begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end else if (parity == uart_frame_pkg::par_none) begin
                            state <= uart_fsm_pkg::st_stop0;
                        end else begin
                            state <= uart_fsm_pkg::st_parity;
                        end
                    end
                end
                uart_fsm_pkg::st_parity: begin
                    if (bit_end) begin
                        state  <= uart_fsm_pkg::st_stop0;
                        perr_q <= (line_s != uart_frame_pkg::parity_bit(parity, word));
                    end
                end
                uart_fsm_pkg::st_stop0: begin
                    if (bit_end) begin
                        state  <= two_stop ? uart_fsm_pkg::st_stop1 : uart_fsm_pkg::st_idle;
                        ferr_q <= !line_s;
                    end
                end
                default: begin
                    if (bit_end) begin
                        state <= uart_fsm_pkg::st_idle;         // Mid stop1
                    end
                end
            endcase
        end
    end

    // Host handshake and overrun
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            rx_req     <= 1'b0;
            rx_overrun <= 1'b0;
        end else begin
            rx_overrun <= frame_done && rx_req;   // Word dropped, held one kept
            if (frame_done && !rx_req) begin
                rx_req <= 1'b1;
            end else if (rx_ack) begin
                rx_req <= 1'b0;
            end
        end
    end

    // Holding register
    always_ff @(posedge clk) begin
        if (frame_done && !rx_req) begin
            rx_data       <= word;
            rx_parity_err <= perr_q;
            rx_frame_err  <= ferr_q | !line_s;      // Final stop bit sampled now
        end
    end

    a_req_until_ack : assert property (
        @(posedge clk) disable iff (!resetn)
        (rx_req && !rx_ack) |=> rx_req
    );

endmodule

`default_nettype wire

// ==== logic/uart_tx.sv ====
// *********************************************************************
// Transmit stage: req/ack capture, serializer and parity generator
// *********************************************************************

`default_nettype none
`include "uart_consts.svh"

module uart_tx (
    input  wire                             clk,
    input  wire                             resetn,
    input  wire                             tick,
    input  wire uart_frame_pkg::data_size_t data_size,
    input  wire uart_frame_pkg::parity_e    parity,
    input  wire                             two_stop,
    input  wire                             tx_req,
    input  wire uart_frame_pkg::data_t      tx_data,
    output logic                            tx_ack,
    output logic                            tx
);

    uart_fsm_pkg::line_state_e state;
    uart_fsm_pkg::sample_cnt_t sample_cnt;
    uart_fsm_pkg::bit_cnt_t    bit_cnt;
    uart_frame_pkg::data_t     shreg;
    uart_frame_pkg::data_t     tx_masked;
    logic                      par_bit;
    logic                      accept;
    logic                      bit_end;
    logic                      last_bit;

    assign tx_masked = tx_data & ~({`UART_DATA_W{1'b1}} << data_size);  // Drop unused bits
    assign accept    = (state == uart_fsm_pkg::st_idle) && tx_req && !tx_ack;
    assign bit_end   = tick && (sample_cnt == uart_fsm_pkg::sample_cnt_t'(`UART_SAMPLES - 1));
    assign last_bit  = ({1'b0, bit_cnt} == data_size - 4'd1);

    // Host handshake, ack held until the host drops req
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            tx_ack <= 1'b0;
        end else if (accept) begin
            tx_ack <= 1'b1;
        end else if (tx_ack && !tx_req) begin
            tx_ack <= 1'b0;
        end
    end

    // Payload, loaded on capture and shifted at each data bit
    always_ff @(posedge clk) begin
        if (accept) begin
            shreg   <= tx_masked;
            par_bit <= uart_frame_pkg::parity_bit(parity, tx_masked);
        end else if (bit_end && state == uart_fsm_pkg::st_data) begin
            shreg <= shreg >> 1;
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state      <= uart_fsm_pkg::st_idle;
            sample_cnt <= '0;
            bit_cnt    <= '0;
            tx         <= 1'b1;                     // Line idles high
        end else if (accept) begin
            state      <= uart_fsm_pkg::st_start;
            sample_cnt <= '0;
            tx         <= 1'b0;                     // Start bit
        end else begin
            if (tick) begin
                sample_cnt <= sample_cnt + 1'b1;    // Wraps every 16 ticks
            end
            if (bit_end) begin
                case (state)
                    uart_fsm_pkg::st_start: begin
                        state   <= uart_fsm_pkg::st_data;
                        bit_cnt <= '0;
                        tx      <= shreg[0];
                    end
                    uart_fsm_pkg::st_data: begin
                        if (!last_bit) begin
                            bit_cnt <= bit_cnt + 1'b1;
                            tx      <= shreg[1];        // Next bit, shreg shifts now
                        end else if (parity == uart_frame_pkg::par_none) begin
                            state <= uart_fsm_pkg::st_stop0;
                            tx    <= 1'b1;
                        end else begin
                            state <= uart_fsm_pkg::st_parity;
                            tx    <= par_bit;
                        end
                    end
                    uart_fsm_pkg::st_parity: begin
                        state <= uart_fsm_pkg::st_stop0;
                        tx    <= 1'b1;
                    end
                    uart_fsm_pkg::st_stop0: begin
                        state <= two_stop ? uart_fsm_pkg::st_stop1 : uart_fsm_pkg::st_idle;
                    end
                    default: begin
                        state <= uart_fsm_pkg::st_idle;     // End of stop1
                        tx    <= 1'b1;
                    end
                endcase
            end
        end
    end

    a_ack_needs_req : assert property (
        @(posedge clk) disable iff (!resetn)
        $rose(tx_ack) |-> $past(tx_req)
    );

    a_idle_line_high : assert property (
        @(posedge clk) disable iff (!resetn)
        (state == uart_fsm_pkg::st_idle) |-> tx
    );

endmodule

`default_nettype wire

// ==== logic/baud_gen.sv ====
// *********************************************************************
// Prescaler emitting the 16x oversampling tick
// *********************************************************************

`default_nettype none

module baud_gen (
    input  wire                            clk,
    input  wire                            resetn,
    input  wire uart_frame_pkg::prescale_t prescale,
    output logic                           tick
);

    uart_frame_pkg::prescale_t count;

    // Also wraps if prescale is lowered below the running count
    assign tick = (count >= prescale);

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            count <= '0;
        end else if (tick) begin
            count <= '0;                            // Wrap
        end else begin
            count <= count + 1'b1;
        end
    end

    a_tick_single : assert property (
        @(posedge clk) disable iff (!resetn)
        (tick && prescale != '0) |=> !tick
    );

endmodule

`default_nettype wire

// ==== logic/uart_fsm_pkg.sv ====
// *********************************************************************
// Bit-sequencing state and counter types for both stages
// *********************************************************************

`default_nettype none
`include "uart_consts.svh"

package uart_fsm_pkg;

    typedef enum logic [2:0] {
        st_idle   = 3'b000,
        st_start  = 3'b001,
        st_data   = 3'b010,
        st_parity = 3'b011,
        st_stop0  = 3'b100,
        st_stop1  = 3'b101
    } line_state_e;

    typedef logic [`UART_SAMPLE_W-1:0]       sample_cnt_t;    // Tick within a bit
    typedef logic [$clog2(`UART_DATA_W)-1:0] bit_cnt_t;       // Data bit index

endpackage

`default_nettype wire

// ==== logic/uart_frame_pkg.sv ====
// *********************************************************************
// Frame-format types and the parity bit function
// *********************************************************************

`default_nettype none
`include "uart_consts.svh"

package uart_frame_pkg;

    typedef logic [`UART_DATA_W-1:0]     data_t;
    typedef logic [`UART_SIZE_W-1:0]     data_size_t;      // 5 - 8
    typedef logic [`UART_PRESCALE_W-1:0] prescale_t;

    typedef enum logic [2:0] {
        par_none   = 3'b000,
        par_odd    = 3'b001,
        par_even   = 3'b010,
        par_stick0 = 3'b100,
        par_stick1 = 3'b101
    } parity_e;

    // Expected parity bit for a word already masked to data_size
    function automatic logic parity_bit(parity_e mode, data_t word);
        case (mode)
            par_odd:    return ~^word;
            par_even:   return ^word;
            par_stick1: return 1'b1;
            default:    return 1'b0;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== logic/uart_consts.svh ====
// *********************************************************************
// Width and count macros shared by the UART core
// *********************************************************************

`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

// Widest data word
`define UART_DATA_W      8

// Oversampling ticks per bit
`define UART_SAMPLES     16

// Prescaler compare value
`define UART_PRESCALE_W  16

// Data-size field, holds 5 to 8
`define UART_SIZE_W      4

// Tick-within-bit counter
`define UART_SAMPLE_W    4

`endif
